// File: src/aes_gf_pkg.sv
package aes_gf_pkg;

    typedef logic [7:0] gf_byte_t;

    localparam gf_byte_t gf_poly_reduce = 8'h1b; // x^8 + x^4 + x^3 + x + 1
    localparam gf_byte_t gf_poly_halve  = 8'h8d; // inverse of x, times x^8 term

    // forward substitution box, row major by high nibble
    localparam gf_byte_t sbox_table [0:255] = '{
    'h63, 'h7c, 'h77, 'h7b, 'hf2, 'h6b, 'h6f, 'hc5, 'h30, 'h01, 'h67, 'h2b, 'hfe, 'hd7, 'hab, 'h76,
    'hca, 'h82, 'hc9, 'h7d, 'hfa, 'h59, 'h47, 'hf0, 'had, 'hd4, 'ha2, 'haf, 'h9c, 'ha4, 'h72, 'hc0,
    'hb7, 'hfd, 'h93, 'h26, 'h36, 'h3f, 'hf7, 'hcc, 'h34, 'ha5, 'he5, 'hf1, 'h71, 'hd8, 'h31, 'h15,
    'h04, 'hc7, 'h23, 'hc3, 'h18, 'h96, 'h05, 'h9a, 'h07, 'h12, 'h80, 'he2, 'heb, 'h27, 'hb2, 'h75,
    'h09, 'h83, 'h2c, 'h1a, 'h1b, 'h6e, 'h5a, 'ha0, 'h52, 'h3b, 'hd6, 'hb3, 'h29, 'he3, 'h2f, 'h84,
    'h53, 'hd1, 'h00, 'hed, 'h20, 'hfc, 'hb1, 'h5b, 'h6a, 'hcb, 'hbe, 'h39, 'h4a, 'h4c, 'h58, 'hcf,
    'hd0, 'hef, 'haa, 'hfb, 'h43, 'h4d, 'h33, 'h85, 'h45, 'hf9, 'h02, 'h7f, 'h50, 'h3c, 'h9f, 'ha8,
    'h51, 'ha3, 'h40, 'h8f, 'h92, 'h9d, 'h38, 'hf5, 'hbc, 'hb6, 'hda, 'h21, 'h10, 'hff, 'hf3, 'hd2,
    'hcd, 'h0c, 'h13, 'hec, 'h5f, 'h97, 'h44, 'h17, 'hc4, 'ha7, 'h7e, 'h3d, 'h64, 'h5d, 'h19, 'h73,
    'h60, 'h81, 'h4f, 'hdc, 'h22, 'h2a, 'h90, 'h88, 'h46, 'hee, 'hb8, 'h14, 'hde, 'h5e, 'h0b, 'hdb,
    'he0, 'h32, 'h3a, 'h0a, 'h49, 'h06, 'h24, 'h5c, 'hc2, 'hd3, 'hac, 'h62, 'h91, 'h95, 'he4, 'h79,
    'he7, 'hc8, 'h37, 'h6d, 'h8d, 'hd5, 'h4e, 'ha9, 'h6c, 'h56, 'hf4, 'hea, 'h65, 'h7a, 'hae, 'h08,
    'hba, 'h78, 'h25, 'h2e, 'h1c, 'ha6, 'hb4, 'hc6, 'he8, 'hdd, 'h74, 'h1f, 'h4b, 'hbd, 'h8b, 'h8a,
    'h70, 'h3e, 'hb5, 'h66, 'h48, 'h03, 'hf6, 'h0e, 'h61, 'h35, 'h57, 'hb9, 'h86, 'hc1, 'h1d, 'h9e,
    'he1, 'hf8, 'h98, 'h11, 'h69, 'hd9, 'h8e, 'h94, 'h9b, 'h1e, 'h87, 'he9, 'hce, 'h55, 'h28, 'hdf,
    'h8c, 'ha1, 'h89, 'h0d, 'hbf, 'he6, 'h42, 'h68, 'h41, 'h99, 'h2d, 'h0f, 'hb0, 'h54, 'hbb, 'h16
    };

    // inverse substitution box
    localparam gf_byte_t inv_sbox_table [0:255] = '{
    'h52, 'h09, 'h6a, 'hd5, 'h30, 'h36, 'ha5, 'h38, 'hbf, 'h40, 'ha3, 'h9e, 'h81, 'hf3, 'hd7, 'hfb,
    'h7c, 'he3, 'h39, 'h82, 'h9b, 'h2f, 'hff, 'h87, 'h34, 'h8e, 'h43, 'h44, 'hc4, 'hde, 'he9, 'hcb,
    'h54, 'h7b, 'h94, 'h32, 'ha6, 'hc2, 'h23, 'h3d, 'hee, 'h4c, 'h95, 'h0b, 'h42, 'hfa, 'hc3, 'h4e,
    'h08, 'h2e, 'ha1, 'h66, 'h28, 'hd9, 'h24, 'hb2, 'h76, 'h5b, 'ha2, 'h49, 'h6d, 'h8b, 'hd1, 'h25,
    'h72, 'hf8, 'hf6, 'h64, 'h86, 'h68, 'h98, 'h16, 'hd4, 'ha4, 'h5c, 'hcc, 'h5d, 'h65, 'hb6, 'h92,
    'h6c, 'h70, 'h48, 'h50, 'hfd, 'hed, 'hb9, 'hda, 'h5e, 'h15, 'h46, 'h57, 'ha7, 'h8d, 'h9d, 'h84,
    'h90, 'hd8, 'hab, 'h00, 'h8c, 'hbc, 'hd3, 'h0a, 'hf7, 'he4, 'h58, 'h05, 'hb8, 'hb3, 'h45, 'h06,
    'hd0, 'h2c, 'h1e, 'h8f, 'hca, 'h3f, 'h0f, 'h02, 'hc1, 'haf, 'hbd, 'h03, 'h01, 'h13, 'h8a, 'h6b,
    'h3a, 'h91, 'h11, 'h41, 'h4f, 'h67, 'hdc, 'hea, 'h97, 'hf2, 'hcf, 'hce, 'hf0, 'hb4, 'he6, 'h73,
    'h96, 'hac, 'h74, 'h22, 'he7, 'had, 'h35, 'h85, 'he2, 'hf9, 'h37, 'he8, 'h1c, 'h75, 'hdf, 'h6e,
    'h47, 'hf1, 'h1a, 'h71, 'h1d, 'h29, 'hc5, 'h89, 'h6f, 'hb7, 'h62, 'h0e, 'haa, 'h18, 'hbe, 'h1b,
    'hfc, 'h56, 'h3e, 'h4b, 'hc6, 'hd2, 'h79, 'h20, 'h9a, 'hdb, 'hc0, 'hfe, 'h78, 'hcd, 'h5a, 'hf4,
    'h1f, 'hdd, 'ha8, 'h33, 'h88, 'h07, 'hc7, 'h31, 'hb1, 'h12, 'h10, 'h59, 'h27, 'h80, 'hec, 'h5f,
    'h60, 'h51, 'h7f, 'ha9, 'h19, 'hb5, 'h4a, 'h0d, 'h2d, 'he5, 'h7a, 'h9f, 'h93, 'hc9, 'h9c, 'hef,
    'ha0, 'he0, 'h3b, 'h4d, 'hae, 'h2a, 'hf5, 'hb0, 'hc8, 'heb, 'hbb, 'h3c, 'h83, 'h53, 'h99, 'h61,
    'h17, 'h2b, 'h04, 'h7e, 'hba, 'h77, 'hd6, 'h26, 'he1, 'h69, 'h14, 'h63, 'h55, 'h21, 'h0c, 'h7d
    };

    function automatic gf_byte_t gf_mul2(gf_byte_t x);
        return {x[6:0], 1'b0} ^ (gf_poly_reduce & {8{x[7]}}); // xtime
    endfunction

    function automatic gf_byte_t gf_div2(gf_byte_t x);
        return {1'b0, x[7:1]} ^ (gf_poly_halve & {8{x[0]}}); // inverse of xtime
    endfunction

    function automatic gf_byte_t gf_mul9(gf_byte_t x);
        gf_byte_t x8;
        x8 = gf_mul2(gf_mul2(gf_mul2(x)));
        return x8 ^ x;
    endfunction

    function automatic gf_byte_t gf_mul11(gf_byte_t x);
        gf_byte_t x2;
        gf_byte_t x8;
        x2 = gf_mul2(x);
        x8 = gf_mul2(gf_mul2(x2));
        return x8 ^ x2 ^ x;
    endfunction

    function automatic gf_byte_t gf_mul13(gf_byte_t x);
        gf_byte_t x4;
        gf_byte_t x8;
        x4 = gf_mul2(gf_mul2(x));
        x8 = gf_mul2(x4);
        return x8 ^ x4 ^ x;
    endfunction

    function automatic gf_byte_t gf_mul14(gf_byte_t x);
        gf_byte_t x2;
        gf_byte_t x4;
        gf_byte_t x8;
        x2 = gf_mul2(x);
        x4 = gf_mul2(x2);
        x8 = gf_mul2(x4);
        return x8 ^ x4 ^ x2;
    endfunction

    // bytewise lookups on one 32-bit word
    function automatic logic [31:0] sub_word(logic [31:0] w);
        return {sbox_table[w[31:24]], sbox_table[w[23:16]],
                sbox_table[w[15:8]], sbox_table[w[7:0]]};
    endfunction

    function automatic logic [31:0] inv_sub_word(logic [31:0] w);
        return {inv_sbox_table[w[31:24]], inv_sbox_table[w[23:16]],
                inv_sbox_table[w[15:8]], inv_sbox_table[w[7:0]]};
    endfunction

endpackage

// File: src/aes_state_pkg.sv
package aes_state_pkg;

    import aes_gf_pkg::*;

    typedef logic [31:0]  aes_word_t;  // one state column
    typedef logic [127:0] aes_block_t; // flat block or round key
    typedef logic [3:0]   aes_round_t;

    // Cipher state, FIPS 197 column-major layout.
    // col[0] and bytes[0] sit at the most significant end of the block,
    // so bytes[4*c + r] is row r of column c.
    typedef union packed {
        aes_block_t           flat;
        aes_word_t [0:3]      col;   // column view for sbox and mix
        gf_byte_t  [0:15]     bytes; // byte view for row shifts
    } aes_state_u;

    localparam aes_round_t aes_num_rounds  = 4'd10;
    localparam aes_round_t aes_first_round = aes_num_rounds - 4'd1; // loaded at accept

    // rcon of round ten, halved back toward 01 on each key step
    localparam gf_byte_t aes_rcon_last = 8'h36;

endpackage

// File: src/aes_dec_ctrl.sv
module aes_dec_ctrl
    import aes_state_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       load,
    output logic       sub_en,
    output logic       mix_en,
    output logic       final_en,
    output logic       key_step,
    output aes_round_t round
);

    logic sub_pend;   // substitution pass on next edge
    logic add_pend;   // key-add pass on next edge
    logic key_pend;   // key step on next edge
    logic round_gt_0;

    assign round_gt_0 = |round;

    // idle whenever no pass is pending
    assign in_ready = ~(sub_pend | add_pend);
    assign load     = in_valid & in_ready;

    assign sub_en   = sub_pend;
    assign mix_en   = add_pend & round_gt_0;  // full inverse round
    assign final_en = add_pend & ~round_gt_0; // last key add only
    assign key_step = key_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            sub_pend <= 1'b0;
            add_pend <= 1'b0;
            key_pend <= 1'b0;
            round    <= '0;
        end else begin
            // one step right after load, then one per substitution pass
            // while rounds remain
            key_pend <= load | (sub_pend & round_gt_0);

            if (load) begin
                round    <= aes_first_round;
                sub_pend <= 1'b1;
            end else if (sub_pend) begin
                sub_pend <= 1'b0;
                add_pend <= 1'b1;
            end else if (add_pend) begin
                add_pend <= 1'b0;
                sub_pend <= round_gt_0; // loop back unless final
                if (round_gt_0) begin
                    round <= round - 4'd1;
                end
            end
        end
    end

endmodule

// File: src/aes_inv_key_sched.sv
module aes_inv_key_sched
    import aes_gf_pkg::*, aes_state_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic       key_step,
    input  aes_block_t in_key,
    output aes_block_t round_key
);

    gf_byte_t  rcon;
    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;
    aes_word_t sub_w3;

    // Undo one forward expansion step. Words three to one come from
    // xor with their left neighbour, word zero needs the new word three
    // through RotWord and SubWord plus the round constant.
    always_comb begin
        w3     = round_key[31:0]  ^ round_key[63:32];
        w2     = round_key[63:32] ^ round_key[95:64];
        w1     = round_key[95:64] ^ round_key[127:96];
        sub_w3 = sub_word(w3);
        w0     = round_key[127:96] ^ {sub_w3[23:0], sub_w3[31:24]} ^ {rcon, 24'h0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            round_key <= '0;
            rcon      <= '0;
        end else if (load) begin
            round_key <= in_key;        // last round key
            rcon      <= aes_rcon_last;
        end else if (key_step) begin
            round_key <= {w0, w1, w2, w3};
            rcon      <= gf_div2(rcon); // 36, 1b, 80, 40 ...
        end
    end

endmodule

// File: src/aes_inv_round.sv
module aes_inv_round
    import aes_gf_pkg::*, aes_state_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic       sub_en,
    input  logic       mix_en,
    input  logic       final_en,
    input  aes_block_t in_block,
    input  aes_block_t in_key,
    input  aes_block_t round_key,
    output aes_block_t out_block
);

    aes_state_u state;
    aes_state_u white_st;
    aes_state_u load_st;
    aes_state_u sub_st;
    aes_state_u add_st;
    aes_state_u mixed_st;
    aes_state_u mix_st;

    // row r rotates right by r columns
    function automatic aes_state_u inv_shift_rows(aes_state_u s);
        aes_state_u r;
        for (int c = 0; c < 4; c++) begin
            for (int b = 0; b < 4; b++) begin
                r.bytes[4*c + b] = s.bytes[4*((c - b + 4) % 4) + b];
            end
        end
        return r;
    endfunction

    function automatic aes_word_t inv_mix_col(aes_word_t w);
        gf_byte_t a0;
        gf_byte_t a1;
        gf_byte_t a2;
        gf_byte_t a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {gf_mul14(a0) ^ gf_mul11(a1) ^ gf_mul13(a2) ^ gf_mul9(a3),
                gf_mul9(a0)  ^ gf_mul14(a1) ^ gf_mul11(a2) ^ gf_mul13(a3),
                gf_mul13(a0) ^ gf_mul9(a1)  ^ gf_mul14(a2) ^ gf_mul11(a3),
                gf_mul11(a0) ^ gf_mul13(a1) ^ gf_mul9(a2)  ^ gf_mul14(a3)};
    endfunction

    always_comb begin
        white_st.flat = in_block ^ in_key; // initial AddRoundKey
        load_st       = inv_shift_rows(white_st);
        add_st.flat   = state.flat ^ round_key;
        for (int c = 0; c < 4; c++) begin
            sub_st.col[c]   = inv_sub_word(state.col[c]);  // four lookups per pass
            mixed_st.col[c] = inv_mix_col(add_st.col[c]);
        end
        mix_st = inv_shift_rows(mixed_st);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state.flat <= '0;
        end else if (load) begin
            state <= load_st;
        end else if (sub_en) begin
            state <= sub_st;
        end else if (mix_en) begin
            state <= mix_st;
        end else if (final_en) begin
            state <= add_st; // plaintext
        end
    end

    assign out_block = state.flat;

endmodule

// File: src/aes_dec_top.sv
module aes_dec_top
    import aes_state_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  aes_block_t in_key,    // last round key of the cipher
    input  aes_block_t in_block,  // ciphertext
    input  logic       in_valid,
    output logic       in_ready,
    output aes_block_t out_block, // plaintext, held until next transfer
    output aes_round_t round,
    output aes_block_t round_key  // cipher key once the run ends
);

    logic load;
    logic sub_en;
    logic mix_en;
    logic final_en;
    logic key_step;

    aes_dec_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .load     (load),
        .sub_en   (sub_en),
        .mix_en   (mix_en),
        .final_en (final_en),
        .key_step (key_step),
        .round    (round)
    );

    aes_inv_key_sched u_key_sched (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .key_step  (key_step),
        .in_key    (in_key),
        .round_key (round_key)
    );

    // key add at each pass uses the schedule register before its step
    aes_inv_round u_round (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .sub_en    (sub_en),
        .mix_en    (mix_en),
        .final_en  (final_en),
        .in_block  (in_block),
        .in_key    (in_key),
        .round_key (round_key),
        .out_block (out_block)
    );

endmodule

// File: testbench/aes_enc_model_pkg.sv
package aes_enc_model_pkg;

    import aes_gf_pkg::*;
    import aes_state_pkg::*;

    // one forward expansion step, round key i to round key i+1
    function automatic aes_block_t next_round_key(aes_block_t k, gf_byte_t rc);
        aes_word_t w0;
        aes_word_t w1;
        aes_word_t w2;
        aes_word_t w3;
        aes_word_t t;
        w0 = k[127:96];
        w1 = k[95:64];
        w2 = k[63:32];
        w3 = k[31:0];
        t  = {w3[23:0], w3[31:24]}; // RotWord
        t  = {sbox_table[t[31:24]], sbox_table[t[23:16]],
              sbox_table[t[15:8]], sbox_table[t[7:0]]};
        w0 = w0 ^ t ^ {rc, 24'h0};
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

    function automatic aes_block_t last_round_key(aes_block_t key);
        aes_block_t k;
        gf_byte_t   rc;
        k  = key;
        rc = 8'h01;
        for (int r = 1; r <= 10; r++) begin
            k  = next_round_key(k, rc);
            rc = gf_mul2(rc);
        end
        return k;
    endfunction

    function automatic aes_block_t encipher(aes_block_t plain, aes_block_t key);
        gf_byte_t   s [0:15];
        gf_byte_t   t [0:15];
        gf_byte_t   a0;
        gf_byte_t   a1;
        gf_byte_t   a2;
        gf_byte_t   a3;
        aes_block_t blk;
        aes_block_t k;
        gf_byte_t   rc;
        k   = key;
        rc  = 8'h01;
        blk = plain ^ k;
        for (int rnd = 1; rnd <= 10; rnd++) begin
            k  = next_round_key(k, rc);
            rc = gf_mul2(rc);
            for (int i = 0; i < 16; i++) begin
                s[i] = sbox_table[blk[127 - 8*i -: 8]];
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[4*c + r] = s[4*((c + r) % 4) + r]; // row r rotates left by r
                end
            end
            for (int c = 0; c < 4; c++) begin
                a0 = t[4*c];
                a1 = t[4*c + 1];
                a2 = t[4*c + 2];
                a3 = t[4*c + 3];
                if (rnd == 10) begin
                    s[4*c]     = a0; // no MixColumns in the last round
                    s[4*c + 1] = a1;
                    s[4*c + 2] = a2;
                    s[4*c + 3] = a3;
                end else begin
                    s[4*c]     = gf_mul2(a0) ^ gf_mul2(a1) ^ a1 ^ a2 ^ a3;
                    s[4*c + 1] = a0 ^ gf_mul2(a1) ^ gf_mul2(a2) ^ a2 ^ a3;
                    s[4*c + 2] = a0 ^ a1 ^ gf_mul2(a2) ^ gf_mul2(a3) ^ a3;
                    s[4*c + 3] = gf_mul2(a0) ^ a0 ^ a1 ^ a2 ^ gf_mul2(a3);
                end
            end
            for (int i = 0; i < 16; i++) begin
                blk[127 - 8*i -: 8] = s[i];
            end
            blk = blk ^ k;
        end
        return blk;
    endfunction

endpackage

// File: testbench/tb_aes_dec.sv
module tb_aes_dec
    import aes_state_pkg::*, aes_enc_model_pkg::*;
();

    localparam int ready_timeout = 50; // cycles
    localparam int done_timeout  = 40;
    localparam int num_random    = 200;
    localparam int run_cycles    = 20;

    // FIPS 197 appendix C.1
    localparam aes_block_t kat_key    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t kat_last   = 128'h13111d7fe3944a17f307a78b4d2b30c5;
    localparam aes_block_t kat_cipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_block_t kat_plain  = 128'h00112233445566778899aabbccddeeff;

    logic       clk;
    logic       rst;
    aes_block_t in_key;
    aes_block_t in_block;
    logic       in_valid;
    logic       in_ready;
    aes_block_t out_block;
    aes_round_t round;
    aes_block_t round_key;

    int seed;

    aes_dec_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_key    (in_key),
        .in_block  (in_block),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_block (out_block),
        .round     (round),
        .round_key (round_key)
    );

    always #10 clk = ~clk;

    // round after n edges of a run, it drops at every key add but the last
    function automatic aes_round_t expected_round(int n);
        int steps;
        steps = (n > 18) ? 9 : n / 2;
        return aes_round_t'(9 - steps);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_block(input aes_block_t got, input aes_block_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s block %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_key(input aes_block_t got, input aes_block_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s key %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_round(input aes_round_t got, input aes_round_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s round %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic random_block(output aes_block_t b);
        for (int i = 0; i < 4; i++) begin
            b[32*i +: 32] = $random(seed);
        end
    endtask

    task automatic offer_block(input aes_block_t blk, input aes_block_t key);
        in_block = blk;
        in_key   = key;
        in_valid = 1'b1;
    endtask

    // returns 2 units after the transfer edge
    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!in_ready) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > ready_timeout) begin
                abort_run("Timeout: in_ready stayed low while a block was offered");
            end
        end
        @(posedge clk); // transfer edge
        #2;
    endtask

    task automatic wait_done(input aes_block_t exp_plain, input aes_block_t exp_key,
                             input string what);
        int n;
        n = 0;
        if (in_ready) begin
            abort_run("in_ready was still high right after a transfer");
        end
        check_round(round, expected_round(0), what);
        while (!in_ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > done_timeout) begin
                abort_run("Timeout: the core never raised in_ready after a transfer");
            end
            check_round(round, expected_round(n), what);
        end
        if (n != run_cycles) begin
            abort_run($sformatf("[FAIL] %0t: %s took %0d cycles, expected %0d",
                                $time, what, n, run_cycles));
        end
        check_block(out_block, exp_plain, what);
        check_key(round_key, exp_key, what);
    endtask

    task automatic run_one(input aes_block_t key, input aes_block_t plain, input string what);
        offer_block(encipher(plain, key), last_round_key(key));
        wait_accept();
        in_valid = 1'b0;
        wait_done(plain, key, what);
    endtask

    initial begin
        aes_block_t key_a;
        aes_block_t plain_a;
        aes_block_t key_b;
        aes_block_t plain_b;
        seed     = 32'h616812c8;
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_key   = '0;
        in_block = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        // idle state out of reset
        if (!in_ready) begin
            abort_run("in_ready was low after reset");
        end
        check_round(round, 4'd0, "after reset");
        check_block(out_block, '0, "after reset");
        check_key(round_key, '0, "after reset");

        // reference model against the standard vector first
        check_block(encipher(kat_plain, kat_key), kat_cipher, "model");
        check_key(last_round_key(kat_key), kat_last, "model");
        offer_block(kat_cipher, kat_last);
        wait_accept();
        in_valid = 1'b0;
        wait_done(kat_plain, kat_key, "known answer");

        for (int i = 0; i < num_random; i++) begin
            random_block(key_a);
            random_block(plain_a);
            run_one(key_a, plain_a, $sformatf("random %0d", i));
        end

        // second block waits with valid high through the whole first run
        random_block(key_a);
        random_block(plain_a);
        random_block(key_b);
        random_block(plain_b);
        offer_block(encipher(plain_a, key_a), last_round_key(key_a));
        wait_accept();
        offer_block(encipher(plain_b, key_b), last_round_key(key_b));
        wait_done(plain_a, key_a, "held valid, first block");
        wait_accept();
        in_valid = 1'b0;
        wait_done(plain_b, key_b, "held valid, second block");

        $display("All tests passed");
        $finish;
    end

endmodule

// File: files.f
src/aes_gf_pkg.sv
src/aes_state_pkg.sv
src/aes_dec_ctrl.sv
src/aes_inv_key_sched.sv
src/aes_inv_round.sv
src/aes_dec_top.sv
testbench/aes_enc_model_pkg.sv
testbench/tb_aes_dec.sv

// File: Bender.yml
package:
  name: aes_dec

sources:
  # packages first, then the core bottom up
  - src/aes_gf_pkg.sv
  - src/aes_state_pkg.sv
  - src/aes_dec_ctrl.sv
  - src/aes_inv_key_sched.sv
  - src/aes_inv_round.sv
  - src/aes_dec_top.sv
  - target: test
    files:
      - testbench/aes_enc_model_pkg.sv
      - testbench/tb_aes_dec.sv
